// ==== hw/blackjack_pkg.sv ====
//*********************************************************************
// Blackjack table package
// Video timing, screen geometry, colors, vector types and game states
//*********************************************************************
`default_nettype none

package blackjack_pkg;

    // 800x600 at 60 Hz with a 40 MHz pixel clock, both syncs active high
    localparam int h_active = 800;
    localparam int h_front  = 40;
    localparam int h_sync   = 128;
    localparam int h_total  = 1056;
    localparam int v_active = 600;
    localparam int v_front  = 1;
    localparam int v_sync   = 4;
    localparam int v_total  = 628;

    typedef logic [10:0] coord_t;
    typedef logic [11:0] mouse_pos_t;
    typedef logic [11:0] rgb_t;
    typedef logic [3:0]  card_value_t;
    typedef logic [5:0]  hand_total_t;
    typedef logic [3:0]  card_count_t;

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_play  = 2'd1,
        st_stand = 2'd2,
        st_bust  = 2'd3
    } game_state_t;

    // Button row shared by deal, hit and stand
    localparam int btn_y_top     = 520;
    localparam int btn_y_bottom  = 560;
    localparam int deal_x_left   = 100;
    localparam int deal_x_right  = 220;
    localparam int hit_x_left    = 340;
    localparam int hit_x_right   = 460;
    localparam int stand_x_left  = 580;
    localparam int stand_x_right = 700;

    localparam int card_x0    = 60;
    localparam int card_y0    = 200;
    localparam int card_w     = 40;
    localparam int card_pitch = 60;
    localparam int card_h     = 120;

    localparam int pointer_size = 8;

    localparam rgb_t col_bg         = 12'h040;
    localparam rgb_t col_btn        = 12'h666;
    localparam rgb_t col_btn_active = 12'hFC0;
    localparam rgb_t col_card       = 12'hEEE;
    localparam rgb_t col_pointer    = 12'hFFF;

    localparam logic [7:0] lfsr_seed = 8'h5A;
    localparam int bust_limit = 21;

endpackage

`default_nettype wire

// ==== hw/vga_timing.sv ====
//*********************************************************************
// VGA timing generator
// Pixel and line counters with registered sync and blanking
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  logic                  clk,
    input  logic                  rst_n,
    output blackjack_pkg::coord_t hcount,
    output blackjack_pkg::coord_t vcount,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  blank
);
    import blackjack_pkg::*;

    coord_t hcount_nxt;
    coord_t vcount_nxt;

    always_comb begin
        hcount_nxt = hcount + 1'b1;
        vcount_nxt = vcount;
        if (hcount == h_total - 1) begin
            hcount_nxt = '0;
            if (vcount == v_total - 1) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vcount + 1'b1;
            end
        end
    end

    // Sync and blank come from the next counts so they line up with the counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            blank  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hsync  <= (hcount_nxt >= h_active + h_front) &&
                      (hcount_nxt < h_active + h_front + h_sync);
            vsync  <= (vcount_nxt >= v_active + v_front) &&
                      (vcount_nxt < v_active + v_front + v_sync);
            blank  <= (hcount_nxt >= h_active) || (vcount_nxt >= v_active);
        end
    end

endmodule

`default_nettype wire

// ==== hw/buttons_click.sv ====
//*********************************************************************
// Button click detector
// Turns a left press over a button into a deal, hit or stand strobe
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module buttons_click (
    input  logic                      clk,
    input  logic                      rst_n,
    input  blackjack_pkg::mouse_pos_t xpos,
    input  blackjack_pkg::mouse_pos_t ypos,
    input  logic                      left,
    output logic                      deal,
    output logic                      hit,
    output logic                      stand
);
    import blackjack_pkg::*;

    logic left_prev;
    logic press;
    logic in_row;

    assign press  = left && !left_prev;
    assign in_row = (ypos >= btn_y_top) && (ypos < btn_y_bottom);

    // The rectangles do not overlap, so at most one strobe fires
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_prev <= 1'b0;
            deal      <= 1'b0;
            hit       <= 1'b0;
            stand     <= 1'b0;
        end else begin
            left_prev <= left;
            deal      <= press && in_row && (xpos >= deal_x_left) && (xpos < deal_x_right);
            hit       <= press && in_row && (xpos >= hit_x_left) && (xpos < hit_x_right);
            stand     <= press && in_row && (xpos >= stand_x_left) && (xpos < stand_x_right);
        end
    end

endmodule

`default_nettype wire

// ==== hw/card_dealer.sv ====
//*********************************************************************
// Card dealer
// 8-bit LFSR card source answering each draw request one cycle later
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module card_dealer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       draw_req,
    output blackjack_pkg::card_value_t card_value,
    output logic                       card_valid
);
    import blackjack_pkg::*;

    logic [7:0] lfsr;
    logic [7:0] lfsr_nxt;

    // Ace counts 11, face cards count 10
    function automatic card_value_t card_of(input logic [7:0] state);
        logic [7:0] rem;
        logic [3:0] rank;
        rem  = state % 8'd13;
        rank = rem[3:0] + 4'd1;
        if (rank == 4'd1) begin
            return 4'd11;
        end else if (rank > 4'd10) begin
            return 4'd10;
        end
        return rank;
    endfunction

    // Taps 8, 6, 5, 4 with feedback into bit 0
    assign lfsr_nxt = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr       <= lfsr_seed;
            card_valid <= 1'b0;
        end else begin
            card_valid <= draw_req;
            if (draw_req) begin
                lfsr <= lfsr_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (draw_req) begin
            card_value <= card_of(lfsr_nxt);
        end
    end

endmodule

`default_nettype wire

// ==== hw/blackjack_fsm.sv ====
//*********************************************************************
// Blackjack game FSM
// Handles deal, hit and stand and keeps the player's card count and total
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module blackjack_fsm (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       deal,
    input  logic                       hit,
    input  logic                       stand,
    input  blackjack_pkg::card_value_t card_value,
    input  logic                       card_valid,
    output logic                       draw_req,
    output blackjack_pkg::hand_total_t hand_total,
    output blackjack_pkg::card_count_t card_count,
    output blackjack_pkg::game_state_t game_state
);
    import blackjack_pkg::*;

    // Cards still to request after the current one
    logic [1:0]  pending;
    // A request is out and its card has not arrived yet
    logic        busy;
    hand_total_t total_sum;

    assign total_sum = hand_total + hand_total_t'(card_value);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            game_state <= st_idle;
            hand_total <= '0;
            card_count <= '0;
            pending    <= '0;
            busy       <= 1'b0;
            draw_req   <= 1'b0;
        end else begin
            draw_req <= 1'b0;
            if (busy && card_valid) begin
                hand_total <= total_sum;
                card_count <= card_count + 1'b1;
                if (total_sum > bust_limit) begin
                    game_state <= st_bust;
                    pending    <= '0;
                    busy       <= 1'b0;
                end else if (pending != '0) begin
                    // Second card of the deal goes out right away
                    pending  <= pending - 1'b1;
                    draw_req <= 1'b1;
                end else begin
                    busy <= 1'b0;
                end
            end else if (!busy) begin
                if (deal) begin
                    game_state <= st_play;
                    hand_total <= '0;
                    card_count <= '0;
                    pending    <= 2'd1;
                    busy       <= 1'b1;
                    draw_req   <= 1'b1;
                end else if (hit && game_state == st_play) begin
                    busy     <= 1'b1;
                    draw_req <= 1'b1;
                end else if (stand && game_state == st_play) begin
                    game_state <= st_stand;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/draw_table.sv ====
//*********************************************************************
// Table drawing stage
// Paints the felt, the three buttons and one bar per dealt card
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module draw_table (
    input  logic                       clk,
    input  logic                       rst_n,
    input  blackjack_pkg::coord_t      hcount,
    input  blackjack_pkg::coord_t      vcount,
    input  logic                       hsync,
    input  logic                       vsync,
    input  logic                       blank,
    input  blackjack_pkg::card_count_t card_count,
    input  blackjack_pkg::game_state_t game_state,
    output blackjack_pkg::coord_t      hcount_out,
    output blackjack_pkg::coord_t      vcount_out,
    output logic                       hsync_out,
    output logic                       vsync_out,
    output logic                       blank_out,
    output blackjack_pkg::rgb_t        rgb
);
    import blackjack_pkg::*;

    coord_t card_off;
    coord_t card_idx;
    logic   in_card;
    logic   in_row;
    logic   play;
    rgb_t   rgb_nxt;

    // Bar index and offset within its pitch
    assign card_off = hcount - coord_t'(card_x0);
    assign card_idx = card_off / coord_t'(card_pitch);
    assign in_card  = (hcount >= card_x0) && (vcount >= card_y0) &&
                      (vcount < card_y0 + card_h) &&
                      (card_off % coord_t'(card_pitch) < card_w) &&
                      (card_idx < card_count);
    assign in_row   = (vcount >= btn_y_top) && (vcount < btn_y_bottom);
    assign play     = (game_state == st_play);

    always_comb begin
        if (blank) begin
            rgb_nxt = '0;
        end else if (in_card) begin
            rgb_nxt = col_card;
        end else if (in_row && hcount >= deal_x_left && hcount < deal_x_right) begin
            rgb_nxt = col_btn_active;
        end else if (in_row && hcount >= hit_x_left && hcount < hit_x_right) begin
            rgb_nxt = play ? col_btn_active : col_btn;
        end else if (in_row && hcount >= stand_x_left && hcount < stand_x_right) begin
            rgb_nxt = play ? col_btn_active : col_btn;
        end else begin
            rgb_nxt = col_bg;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            blank_out  <= 1'b0;
            rgb        <= '0;
        end else begin
            hcount_out <= hcount;
            vcount_out <= vcount;
            hsync_out  <= hsync;
            vsync_out  <= vsync;
            blank_out  <= blank;
            rgb        <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hw/draw_mouse.sv ====
//*********************************************************************
// Pointer drawing stage
// Overlays a square pointer at the mouse position
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module draw_mouse (
    input  logic                      clk,
    input  logic                      rst_n,
    input  blackjack_pkg::coord_t     hcount,
    input  blackjack_pkg::coord_t     vcount,
    input  logic                      hsync,
    input  logic                      vsync,
    input  logic                      blank,
    input  blackjack_pkg::rgb_t       rgb,
    input  blackjack_pkg::mouse_pos_t xpos,
    input  blackjack_pkg::mouse_pos_t ypos,
    output logic                      hsync_out,
    output logic                      vsync_out,
    output blackjack_pkg::rgb_t       rgb_out
);
    import blackjack_pkg::*;

    logic in_pointer;

    // Top-left corner of the square sits on the mouse position
    assign in_pointer = (hcount >= xpos) && (hcount < xpos + pointer_size) &&
                        (vcount >= ypos) && (vcount < ypos + pointer_size);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
            rgb_out   <= '0;
        end else begin
            hsync_out <= hsync;
            vsync_out <= vsync;
            rgb_out   <= (in_pointer && !blank) ? col_pointer : rgb;
        end
    end

endmodule

`default_nettype wire

// ==== hw/top_blackjack.sv ====
//*********************************************************************
// Blackjack table top level
// Raster, drawing pipeline, click detection, game FSM and card dealer
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module top_blackjack (
    input  logic                       clk,
    input  logic                       rst_n,
    input  blackjack_pkg::mouse_pos_t  xpos,
    input  blackjack_pkg::mouse_pos_t  ypos,
    input  logic                       left,
    output logic                       hs,
    output logic                       vs,
    output logic [3:0]                 r,
    output logic [3:0]                 g,
    output logic [3:0]                 b,
    output blackjack_pkg::hand_total_t hand_total,
    output blackjack_pkg::game_state_t game_state
);
    import blackjack_pkg::*;

    coord_t      tim_hcount;
    coord_t      tim_vcount;
    logic        tim_hsync;
    logic        tim_vsync;
    logic        tim_blank;
    coord_t      tbl_hcount;
    coord_t      tbl_vcount;
    logic        tbl_hsync;
    logic        tbl_vsync;
    logic        tbl_blank;
    rgb_t        tbl_rgb;
    rgb_t        mouse_rgb;
    logic        deal;
    logic        hit;
    logic        stand;
    logic        draw_req;
    card_value_t card_value;
    logic        card_valid;
    card_count_t card_count;

    assign {r, g, b} = mouse_rgb;

    vga_timing u_vga_timing (
        .clk,
        .rst_n,
        .hcount (tim_hcount),
        .vcount (tim_vcount),
        .hsync  (tim_hsync),
        .vsync  (tim_vsync),
        .blank  (tim_blank)
    );

    buttons_click u_buttons_click (
        .clk,
        .rst_n,
        .xpos,
        .ypos,
        .left,
        .deal,
        .hit,
        .stand
    );

    card_dealer u_card_dealer (
        .clk,
        .rst_n,
        .draw_req,
        .card_value,
        .card_valid
    );

    blackjack_fsm u_blackjack_fsm (
        .clk,
        .rst_n,
        .deal,
        .hit,
        .stand,
        .card_value,
        .card_valid,
        .draw_req,
        .hand_total,
        .card_count,
        .game_state
    );

    draw_table u_draw_table (
        .clk,
        .rst_n,
        .hcount     (tim_hcount),
        .vcount     (tim_vcount),
        .hsync      (tim_hsync),
        .vsync      (tim_vsync),
        .blank      (tim_blank),
        .card_count,
        .game_state,
        .hcount_out (tbl_hcount),
        .vcount_out (tbl_vcount),
        .hsync_out  (tbl_hsync),
        .vsync_out  (tbl_vsync),
        .blank_out  (tbl_blank),
        .rgb        (tbl_rgb)
    );

    draw_mouse u_draw_mouse (
        .clk,
        .rst_n,
        .hcount    (tbl_hcount),
        .vcount    (tbl_vcount),
        .hsync     (tbl_hsync),
        .vsync     (tbl_vsync),
        .blank     (tbl_blank),
        .rgb       (tbl_rgb),
        .xpos,
        .ypos,
        .hsync_out (hs),
        .vsync_out (vs),
        .rgb_out   (mouse_rgb)
    );

endmodule

`default_nettype wire

// ==== dv/blackjack_assertions.sv ====
//*********************************************************************
// Blackjack FSM assertions
// Checks the click strobes, the draw request, the hand total and reset
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module blackjack_assertions (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       deal,
    input logic                       hit,
    input logic                       stand,
    input logic                       draw_req,
    input blackjack_pkg::hand_total_t hand_total,
    input blackjack_pkg::game_state_t game_state
);
    import blackjack_pkg::*;

    // Number of assertion failures so far
    int error_count = 0;

    // The strobes arrive from buttons_click
    strobes_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0({deal, hit, stand})
    ) else begin
        $error("More than one of deal, hit and stand is high in the same cycle");
        error_count++;
    end

    draw_req_single: assert property (
        @(posedge clk) disable iff (!rst_n) draw_req |=> !draw_req
    ) else begin
        $error("draw_req stayed high for two cycles");
        error_count++;
    end

    total_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) (game_state != st_bust) |-> (hand_total <= bust_limit)
    ) else begin
        $error("Hand total is above the bust limit outside the bust state");
        error_count++;
    end

    idle_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> (game_state == st_idle)
    ) else begin
        $error("Game state is not idle when reset is released");
        error_count++;
    end

endmodule

bind blackjack_fsm blackjack_assertions u_blackjack_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .deal       (deal),
    .hit        (hit),
    .stand      (stand),
    .draw_req   (draw_req),
    .hand_total (hand_total),
    .game_state (game_state)
);

`default_nettype wire

// ==== dv/tb_top_blackjack.sv ====
//*********************************************************************
// Blackjack table testbench
// Clicks through a table of game actions against an LFSR card model,
// then checks the sync timing and the mouse pointer on the raster
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_top_blackjack;
    import blackjack_pkg::*;

    localparam int clk_period     = 10;
    localparam int n_rows         = 14;
    localparam int timeout_cycles = n_rows * 20 + 2 * h_total * v_total;
    // Pointer test spot on plain felt clear of cards and buttons
    localparam int ptr_x = 400;
    localparam int ptr_y = 400;

    logic        clk;
    logic        rst_n;
    mouse_pos_t  xpos;
    mouse_pos_t  ypos;
    logic        left;
    logic        hs;
    logic        vs;
    logic [3:0]  r;
    logic [3:0]  g;
    logic [3:0]  b;
    hand_total_t hand_total;
    game_state_t game_state;

    // Stimulus table with one click per row
    string       row_name  [n_rows];
    int          row_x     [n_rows];
    int          row_y     [n_rows];
    bit          row_deal  [n_rows];
    int          row_cards [n_rows];
    game_state_t row_state [n_rows];

    logic [7:0] model_lfsr;
    int         exp_total;
    int         exp_count;
    int         test_count;
    int         fail_count;

    top_blackjack top_blackjack_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .xpos       (xpos),
        .ypos       (ypos),
        .left       (left),
        .hs         (hs),
        .vs         (vs),
        .r          (r),
        .g          (g),
        .b          (b),
        .hand_total (hand_total),
        .game_state (game_state)
    );

    always #(clk_period / 2) clk = ~clk;

    initial begin
        #(timeout_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles);
        $display("Simulation failed");
        $finish;
    end

    task automatic set_row(input int idx, input string name, input int x, input int y,
                           input bit restart, input int cards, input game_state_t state);
        row_name[idx]  = name;
        row_x[idx]     = x;
        row_y[idx]     = y;
        row_deal[idx]  = restart;
        row_cards[idx] = cards;
        row_state[idx] = state;
    endtask

    // Reference card source built as a Fibonacci LFSR with taps 8, 6, 5 and 4
    task automatic draw_model_card(output int value);
        logic fb;
        int   rank;
        fb         = model_lfsr[7] ^ model_lfsr[5] ^ model_lfsr[4] ^ model_lfsr[3];
        model_lfsr = {model_lfsr[6:0], fb};
        rank       = int'(model_lfsr) % 13 + 1;
        if (rank == 1) begin
            value = 11;
        end else if (rank > 10) begin
            value = 10;
        end else begin
            value = rank;
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        test_count++;
        if (ok) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            fail_count++;
            $display("Test %0d %s: FAILED", test_count, name);
        end
    endtask

    task automatic run_row(input int idx);
        int value;
        bit ok;
        ok   = 1'b1;
        xpos = mouse_pos_t'(row_x[idx]);
        ypos = mouse_pos_t'(row_y[idx]);
        left = 1'b1;
        repeat (3) @(negedge clk);
        left = 1'b0;
        repeat (10) @(negedge clk);
        if (row_deal[idx]) begin
            exp_total = 0;
            exp_count = 0;
        end
        repeat (row_cards[idx]) begin
            draw_model_card(value);
            exp_total += value;
            exp_count++;
        end
        assert (hand_total == hand_total_t'(exp_total)) else begin
            $display("ERROR at %0t: hand_total expected %0d, actual %0d",
                     $time, exp_total, hand_total);
            ok = 1'b0;
        end
        assert (game_state == row_state[idx]) else begin
            $display("ERROR at %0t: game_state expected %s, actual %s",
                     $time, row_state[idx].name(), game_state.name());
            ok = 1'b0;
        end
        assert (top_blackjack_i.card_count == card_count_t'(exp_count)) else begin
            $display("ERROR at %0t: card_count expected %0d, actual %0d",
                     $time, exp_count, top_blackjack_i.card_count);
            ok = 1'b0;
        end
        report_test(row_name[idx], ok);
    endtask

    function automatic logic sync_level(input bit vertical);
        return vertical ? vs : hs;
    endfunction

    // Returns on the first falling clock edge where the chosen sync has just changed to level
    task automatic wait_sync_edge(input bit vertical, input logic level);
        logic prev;
        prev = sync_level(vertical);
        @(negedge clk);
        while (!(sync_level(vertical) == level && prev != level)) begin
            prev = sync_level(vertical);
            @(negedge clk);
        end
    endtask

    task automatic check_hsync();
        int   high_cycles;
        int   period_cycles;
        logic hs_prev;
        bit   ok;
        ok = 1'b1;
        wait_sync_edge(1'b0, 1'b1);
        repeat (2) begin
            high_cycles   = 0;
            period_cycles = 0;
            do begin
                if (hs) begin
                    high_cycles++;
                end
                period_cycles++;
                hs_prev = hs;
                @(negedge clk);
            end while (!(hs && !hs_prev));
            assert (period_cycles == h_total) else begin
                $display("ERROR at %0t: hs period expected %0d, actual %0d",
                         $time, h_total, period_cycles);
                ok = 1'b0;
            end
            assert (high_cycles == h_sync) else begin
                $display("ERROR at %0t: hs width expected %0d, actual %0d",
                         $time, h_sync, high_cycles);
                ok = 1'b0;
            end
        end
        report_test("hsync period and width", ok);
    endtask

    // Ends on the edge where vs falls, which is pixel 0 of the line after the pulse
    task automatic check_vsync();
        int width;
        bit ok;
        ok = 1'b1;
        wait_sync_edge(1'b1, 1'b1);
        width = 0;
        while (vs) begin
            width++;
            @(negedge clk);
        end
        assert (width == v_sync * h_total) else begin
            $display("ERROR at %0t: vs width expected %0d, actual %0d",
                     $time, v_sync * h_total, width);
            ok = 1'b0;
        end
        report_test("vsync width", ok);
    endtask

    task automatic check_pointer();
        bit ok;
        ok = 1'b1;
        // Count hs pulses from the line after vs up to the line above the pointer
        repeat (v_total - (v_active + v_front + v_sync) + ptr_y) begin
            wait_sync_edge(1'b0, 1'b1);
        end
        // The hs rise sits on pixel h_active + h_front
        repeat (h_total - (h_active + h_front) + ptr_x) @(negedge clk);
        assert ({r, g, b} == 12'hFFF) else begin
            $display("ERROR at %0t: rgb expected %h, actual %h", $time, 12'hFFF, {r, g, b});
            ok = 1'b0;
        end
        repeat (pointer_size + 4) @(negedge clk);
        assert ({r, g, b} == col_bg) else begin
            $display("ERROR at %0t: rgb expected %h, actual %h", $time, col_bg, {r, g, b});
            ok = 1'b0;
        end
        report_test("mouse pointer pixel", ok);
    endtask

    task automatic check_bound_assertions();
        int errors;
        bit ok;
        ok     = 1'b1;
        errors = top_blackjack_i.u_blackjack_fsm.u_blackjack_assertions.error_count;
        assert (errors == 0) else begin
            $display("The bound assertions on the game FSM failed %0d times", errors);
            ok = 1'b0;
        end
        report_test("bound FSM assertions", ok);
    endtask

    initial begin
        int idx;
        clk        = 1'b0;
        rst_n      = 1'b0;
        xpos       = '0;
        ypos       = '0;
        left       = 1'b0;
        model_lfsr = lfsr_seed;
        exp_total  = 0;
        exp_count  = 0;
        test_count = 0;
        fail_count = 0;

        set_row(0,  "deal",                160, 540, 1'b1, 2, st_play);
        set_row(1,  "hit",                 400, 540, 1'b0, 1, st_play);
        set_row(2,  "hit to bust",         400, 540, 1'b0, 1, st_bust);
        set_row(3,  "hit after bust",      400, 540, 1'b0, 0, st_bust);
        set_row(4,  "deal after bust",     160, 540, 1'b1, 2, st_play);
        set_row(5,  "stand",               640, 540, 1'b0, 0, st_stand);
        set_row(6,  "hit after stand",     400, 540, 1'b0, 0, st_stand);
        set_row(7,  "click on felt",       400, 400, 1'b0, 0, st_stand);
        set_row(8,  "deal after stand",    160, 540, 1'b1, 2, st_play);
        set_row(9,  "click between keys",  280, 540, 1'b0, 0, st_play);
        set_row(10, "hit to bust again",   400, 540, 1'b0, 1, st_bust);
        set_row(11, "deal",                160, 540, 1'b1, 2, st_play);
        set_row(12, "hit",                 400, 540, 1'b0, 1, st_play);
        set_row(13, "stand",               640, 540, 1'b0, 0, st_stand);

        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (idx = 0; idx < n_rows; idx++) begin
            run_row(idx);
        end

        check_hsync();
        xpos = mouse_pos_t'(ptr_x);
        ypos = mouse_pos_t'(ptr_y);
        check_vsync();
        check_pointer();
        check_bound_assertions();

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 test_count, test_count - fail_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hw/blackjack_pkg.sv
hw/vga_timing.sv
hw/buttons_click.sv
hw/card_dealer.sv
hw/blackjack_fsm.sv
hw/draw_table.sv
hw/draw_mouse.sv
hw/top_blackjack.sv
dv/blackjack_assertions.sv
dv/tb_top_blackjack.sv

// ==== Bender.yml ====
package:
  name: vga_blackjack

sources:
  - hw/blackjack_pkg.sv
  - hw/vga_timing.sv
  - hw/buttons_click.sv
  - hw/card_dealer.sv
  - hw/blackjack_fsm.sv
  - hw/draw_table.sv
  - hw/draw_mouse.sv
  - hw/top_blackjack.sv
  - target: test
    files:
      - dv/blackjack_assertions.sv
      - dv/tb_top_blackjack.sv
